//--- rtl/dbg_cfg_pkg.sv
//////////////////////////////////////////////////////////////////////
// Debug tap configuration definitions
// Register map, mode encodings and the settings word layout
//////////////////////////////////////////////////////////////////////

package dbg_cfg_pkg;

   // One register write on the settings bus
   typedef struct packed {
      logic        stb;   // Write strobe
      logic [7:0]  addr;  // Register address
      logic [31:0] data;  // Write data
   } setting_bus_t;

   //////////////////////////////////////////////////////////////////////
   // Register map
   localparam logic [7:0] DBG_SR_BASE    = 8'd64;
   localparam logic [7:0] DBG_SR_MODE    = 8'd0;  // Capture source select
   localparam logic [7:0] DBG_SR_FREQ    = 8'd1;  // Tone phase step
   localparam logic [7:0] DBG_SR_ECHO    = 8'd2;  // Echo word, I low / Q high
   localparam logic [7:0] DBG_SR_TESTLEN = 8'd3;  // Burst length, log2

   // Values of the mode register, anything else falls to the default
   typedef enum logic [7:0] {
      MODE_ADC   = 8'd0,  // Raw ADC pass-through
      MODE_TONE  = 8'd1,  // Quadrature phase ramp
      MODE_BURST = 8'd2,  // Timed all-ones burst, then marker
      MODE_COUNT = 8'd3,  // Free-running up-counters
      MODE_ZERO  = 8'd4,  // All off
      MODE_ONES  = 8'd5,  // All on
      MODE_I_OFF = 8'd6,  // I off, Q on
      MODE_ECHO  = 8'd7   // Echo register contents
   } dbg_mode_e;

   typedef logic [15:0] phase_inc_t;  // Tone step per sample
   typedef logic [3:0]  burst_log_t;  // log2 of burst length

   // Live configuration seen by the datapath
   typedef struct packed {
      dbg_mode_e   mode;
      phase_inc_t  freq;
      logic [31:0] echo;
      burst_log_t  len_log;
   } dbg_cfg_t;

endpackage

//--- rtl/dbg_sample_pkg.sv
//////////////////////////////////////////////////////////////////////
// Debug tap sample definitions
// Word widths, fixed patterns and output credit limits
//////////////////////////////////////////////////////////////////////

package dbg_sample_pkg;

   typedef logic [13:0] adc_word_t;  // Raw converter word
   typedef logic [14:0] dbg_word_t;  // One output component

   // I/Q pair as it leaves the tap
   typedef struct packed {
      dbg_word_t i;
      dbg_word_t q;
   } iq_sample_t;

   typedef logic [15:0] burst_count_t;

   localparam dbg_word_t DBG_ONES         = '1;
   localparam dbg_word_t DBG_MARK_I       = 15'h3EEF;  // End-of-burst marker
   localparam dbg_word_t DBG_MARK_Q       = 15'h3ABE;
   localparam dbg_word_t DBG_COUNT_Q_INIT = 15'h4000;  // Q counter starts half way

   // Q ramp leads I by 90 degrees
   localparam logic [15:0] DBG_QUARTER_TURN = 16'h4000;

   // Sink side credits
   typedef logic [3:0] credit_count_t;
   localparam credit_count_t DBG_MAX_CREDITS = 4'd15;

endpackage

//--- rtl/debug_settings.sv
//////////////////////////////////////////////////////////////////////
// Debug tap settings registers
// Decodes settings bus writes into the tap configuration
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module debug_settings
   import dbg_cfg_pkg::*;
(
   input  logic         dsp_clk,
   input  logic         dsp_rst,
   input  setting_bus_t set_i,         // Register write port
   output dbg_cfg_t     cfg_o,         // Current configuration
   output logic         burst_load_o   // Restart the burst
);

   logic wr_mode;
   logic wr_freq;
   logic wr_echo;
   logic wr_len;

   // Address decode, one hit per register
   always_comb begin
      wr_mode = set_i.stb && (set_i.addr == DBG_SR_BASE + DBG_SR_MODE);
      wr_freq = set_i.stb && (set_i.addr == DBG_SR_BASE + DBG_SR_FREQ);
      wr_echo = set_i.stb && (set_i.addr == DBG_SR_BASE + DBG_SR_ECHO);
      wr_len  = set_i.stb && (set_i.addr == DBG_SR_BASE + DBG_SR_TESTLEN);
   end

   //////////////////////////////////////////////////////////////////////
   // Configuration registers
   always_ff @(posedge dsp_clk) begin
      if (dsp_rst) begin
         cfg_o.mode    <= MODE_ADC;
         cfg_o.freq    <= '0;
         cfg_o.echo    <= '0;
         cfg_o.len_log <= '0;
         burst_load_o  <= 1'b0;
      end else begin
         burst_load_o <= 1'b0;  // Single cycle pulse
         if (wr_mode) begin
            cfg_o.mode <= dbg_mode_e'(set_i.data[7:0]);
            // Every burst write restarts, even when already in burst
            if (set_i.data[7:0] == MODE_BURST) begin
               burst_load_o <= 1'b1;
            end
         end
         if (wr_freq) begin
            cfg_o.freq <= set_i.data[15:0];
         end
         if (wr_echo) begin
            cfg_o.echo <= set_i.data;
         end
         if (wr_len) begin
            cfg_o.len_log <= set_i.data[3:0];  // Up to 2^15 samples
         end
      end
   end

endmodule

//--- rtl/phase_ramp_gen.sv
//////////////////////////////////////////////////////////////////////
// Quadrature tone source
// Phase accumulator with I and Q ramps a quarter turn apart
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module phase_ramp_gen
   import dbg_cfg_pkg::*;
   import dbg_sample_pkg::*;
(
   input  logic       dsp_clk,
   input  logic       dsp_rst,
   input  phase_inc_t freq_i,     // Step per sent sample
   input  logic       advance_i,  // Sample taken this cycle
   output iq_sample_t tone_o
);

   phase_inc_t phase;    // Accumulated phase, I channel
   phase_inc_t phase_q;  // Shifted copy for Q

   // Accumulator only moves when the selector takes a sample
   always_ff @(posedge dsp_clk) begin
      if (dsp_rst) begin
         phase <= '0;
      end else if (advance_i) begin
         phase <= phase + freq_i;  // Wraps mod 2^16
      end
   end

   // Quarter turn offset, wraps naturally in 16 bits
   assign phase_q = phase + DBG_QUARTER_TURN;

   // Top 15 bits of each phase
   assign tone_o.i = phase[15:1];
   assign tone_o.q = phase_q[15:1];

endmodule

//--- rtl/test_pattern_gen.sv
//////////////////////////////////////////////////////////////////////
// Counter pattern source
// I/Q up-counters and the burst length down-counter
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module test_pattern_gen
   import dbg_cfg_pkg::*;
   import dbg_sample_pkg::*;
(
   input  logic       dsp_clk,
   input  logic       dsp_rst,
   input  logic       advance_i,       // Sample taken this cycle
   input  logic       burst_load_i,    // Reload burst length
   input  burst_log_t len_log_i,       // log2 of burst length
   output iq_sample_t count_o,         // Current counter pair
   output logic       burst_active_o   // Burst still running
);

   dbg_word_t    cnt_i;
   dbg_word_t    cnt_q;
   burst_count_t burst_cnt;

   //////////////////////////////////////////////////////////////////////
   // Up-counters, step on every sent sample whatever the mode
   always_ff @(posedge dsp_clk) begin
      if (dsp_rst) begin
         cnt_i <= '0;
         cnt_q <= DBG_COUNT_Q_INIT;
      end else if (advance_i) begin
         cnt_i <= cnt_i + 1'b1;  // Free wrap at 15 bits
         cnt_q <= cnt_q + 1'b1;
      end
   end

   assign count_o.i = cnt_i;
   assign count_o.q = cnt_q;

   //////////////////////////////////////////////////////////////////////
   // Burst length counter
   always_ff @(posedge dsp_clk) begin
      if (dsp_rst) begin
         burst_cnt <= '0;
      end else if (burst_load_i) begin
         burst_cnt <= burst_count_t'(1) << len_log_i;  // 2^len_log
      end else if (advance_i && (burst_cnt != '0)) begin
         burst_cnt <= burst_cnt - 1'b1;
      end
   end

   // Last ones sample goes out while count is 1
   assign burst_active_o = (burst_cnt != '0);

endmodule

//--- rtl/capture_select.sv
//////////////////////////////////////////////////////////////////////
// Capture selector
// Picks the source by mode, spends sink credits and registers
// one output sample per credit
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module capture_select
   import dbg_cfg_pkg::*;
   import dbg_sample_pkg::*;
(
   input  logic        dsp_clk,
   input  logic        dsp_rst,
   input  dbg_mode_e   mode_i,          // Source select
   input  logic [31:0] echo_i,          // Echo register
   input  adc_word_t   adc_a_i,
   input  adc_word_t   adc_b_i,
   input  iq_sample_t  tone_i,          // Phase ramp source
   input  iq_sample_t  count_i,         // Counter source
   input  logic        burst_active_i,
   input  logic        credit_i,        // One free slot at the sink
   output logic        advance_o,       // Step both sources
   output logic        dbg_valid_o,
   output iq_sample_t  dbg_sample_o
);

   credit_count_t credit_cnt;
   logic          send;
   iq_sample_t    sel_sample;

   //////////////////////////////////////////////////////////////////////
   // Credit tracking
   assign send      = (credit_cnt != '0);  // Any credit left, send now
   assign advance_o = send;

   always_ff @(posedge dsp_clk) begin
      if (dsp_rst) begin
         credit_cnt  <= '0;
         dbg_valid_o <= 1'b0;
      end else begin
         dbg_valid_o <= send;
         case ({credit_i, send})
            2'b10: begin
               if (credit_cnt != DBG_MAX_CREDITS) begin  // Saturate
                  credit_cnt <= credit_cnt + 1'b1;
               end
            end
            2'b01: credit_cnt <= credit_cnt - 1'b1;
            default: ;  // Grant and spend cancel, or idle
         endcase
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Source select
   always_comb begin
      case (mode_i)
         MODE_ADC: begin
            sel_sample.i = {adc_a_i[13], adc_a_i};  // Sign extend
            sel_sample.q = {adc_b_i[13], adc_b_i};
         end
         MODE_TONE:  sel_sample = tone_i;
         MODE_BURST: begin
            if (burst_active_i) begin
               sel_sample.i = DBG_ONES;
               sel_sample.q = DBG_ONES;
            end else begin
               sel_sample.i = DBG_MARK_I;  // Burst done marker
               sel_sample.q = DBG_MARK_Q;
            end
         end
         MODE_COUNT: sel_sample = count_i;
         MODE_ZERO: begin
            sel_sample.i = '0;
            sel_sample.q = '0;
         end
         MODE_ONES: begin
            sel_sample.i = DBG_ONES;
            sel_sample.q = DBG_ONES;
         end
         MODE_I_OFF: begin
            sel_sample.i = '0;
            sel_sample.q = DBG_ONES;
         end
         MODE_ECHO: begin
            sel_sample.i = echo_i[14:0];
            sel_sample.q = echo_i[30:16];
         end
         default: begin
            // A channel shifted up one bit on both outputs
            sel_sample.i = {adc_a_i, 1'b0};
            sel_sample.q = {adc_a_i, 1'b0};
         end
      endcase
   end

   // Output word, loaded only when a sample is sent
   always_ff @(posedge dsp_clk) begin
      if (send) begin
         dbg_sample_o <= sel_sample;
      end
   end

endmodule

//--- rtl/dsp_debug_tap.sv
//////////////////////////////////////////////////////////////////////
// Debug capture tap top level
// Streams a selected I/Q source to the capture port under credits
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module dsp_debug_tap
   import dbg_cfg_pkg::*;
   import dbg_sample_pkg::*;
(
   input  logic         dsp_clk,
   input  logic         dsp_rst,
   input  setting_bus_t set_i,         // Register writes
   input  adc_word_t    adc_a_i,
   input  adc_word_t    adc_b_i,
   input  logic         credit_i,      // Sink credit pulse
   output logic         dbg_valid_o,
   output iq_sample_t   dbg_sample_o
);

   dbg_cfg_t   cfg;
   logic       burst_load;
   logic       advance;       // Sample sent, sources step
   iq_sample_t tone;
   iq_sample_t count;
   logic       burst_active;

   debug_settings i_settings (
      .dsp_clk      (dsp_clk),
      .dsp_rst      (dsp_rst),
      .set_i        (set_i),
      .cfg_o        (cfg),
      .burst_load_o (burst_load)
   );

   phase_ramp_gen i_ramp (
      .dsp_clk   (dsp_clk),
      .dsp_rst   (dsp_rst),
      .freq_i    (cfg.freq),
      .advance_i (advance),
      .tone_o    (tone)
   );

   test_pattern_gen i_pattern (
      .dsp_clk        (dsp_clk),
      .dsp_rst        (dsp_rst),
      .advance_i      (advance),
      .burst_load_i   (burst_load),
      .len_log_i      (cfg.len_log),
      .count_o        (count),
      .burst_active_o (burst_active)
   );

   capture_select i_select (
      .dsp_clk        (dsp_clk),
      .dsp_rst        (dsp_rst),
      .mode_i         (cfg.mode),
      .echo_i         (cfg.echo),
      .adc_a_i        (adc_a_i),
      .adc_b_i        (adc_b_i),
      .tone_i         (tone),
      .count_i        (count),
      .burst_active_i (burst_active),
      .credit_i       (credit_i),
      .advance_o      (advance),
      .dbg_valid_o    (dbg_valid_o),
      .dbg_sample_o   (dbg_sample_o)
   );

endmodule

//--- verif/dsp_debug_tap_sva.sv
//////////////////////////////////////////////////////////////////////
// Credit and valid checks for the capture selector
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module dsp_debug_tap_sva
   import dbg_sample_pkg::*;
(
   input logic          dsp_clk,
   input logic          dsp_rst,
   input logic          credit_i,      // Sink credit pulse
   input credit_count_t credit_cnt_i,  // Selector credit count
   input logic          valid_i        // Output valid
);

   // No credit in hand, no sample next cycle
   valid_needs_credit: assert property (
      @(posedge dsp_clk) disable iff (dsp_rst) (credit_cnt_i == '0) |=> !valid_i
   ) else $error("Valid raised with no credit in hand");

   // A granted credit stays counted, no wrap past the limit
   credit_kept: assert property (
      @(posedge dsp_clk) disable iff (dsp_rst) credit_i |=> (credit_cnt_i != '0)
   ) else $error("Credit lost or count wrapped past the sink limit");

   // Output quiet while reset is applied
   valid_low_in_reset: assert property (
      @(posedge dsp_clk) dsp_rst |=> !valid_i
   ) else $error("Valid high during reset");

endmodule

bind capture_select dsp_debug_tap_sva i_sva (
   .dsp_clk      (dsp_clk),
   .dsp_rst      (dsp_rst),
   .credit_i     (credit_i),
   .credit_cnt_i (credit_cnt),
   .valid_i      (dbg_valid_o)
);

//--- verif/tb_dsp_debug_tap.sv
//////////////////////////////////////////////////////////////////////
// Testbench for the debug capture tap
// Replays the test table, grants sink credits at random gaps and
// checks each sample against a model of the tap sources
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_dsp_debug_tap
   import dbg_cfg_pkg::*;
   import dbg_sample_pkg::*;
();

   localparam string TEST_FILE = "verif/debug_tap_tests.txt";

   logic         dsp_clk;
   logic         dsp_rst;
   setting_bus_t set_bus;     // Register writes into the tap
   adc_word_t    adc_a;
   adc_word_t    adc_b;
   logic         credit;      // Sink credit pulse
   logic         dbg_valid;
   iq_sample_t   dbg_sample;

   // Test table, one entry per line of the data file
   string        t_name[$];
   logic [7:0]   t_mode[$];
   phase_inc_t   t_freq[$];
   logic [31:0]  t_echo[$];
   burst_log_t   t_len[$];
   adc_word_t    t_adc_a[$];
   adc_word_t    t_adc_b[$];
   bit           t_restart[$];
   int unsigned  t_count[$];

   // Model of the tap sources
   phase_inc_t   m_phase;
   dbg_word_t    m_cnt_i;
   dbg_word_t    m_cnt_q;
   burst_count_t m_burst;
   logic [7:0]   cur_mode;    // Mode register as last written

   int unsigned  granted;     // Credits given in this test
   int unsigned  collected;   // Samples seen in this test
   int unsigned  cycles      = 0;
   int unsigned  cycle_limit = 200;

   dsp_debug_tap i_dut (
      .dsp_clk      (dsp_clk),
      .dsp_rst      (dsp_rst),
      .set_i        (set_bus),
      .adc_a_i      (adc_a),
      .adc_b_i      (adc_b),
      .credit_i     (credit),
      .dbg_valid_o  (dbg_valid),
      .dbg_sample_o (dbg_sample)
   );

   always #50 dsp_clk = ~dsp_clk;  // 100 ns period

   // Run length guard
   always @(posedge dsp_clk) begin
      cycles <= cycles + 1;
      if (cycles >= cycle_limit) begin
         $display("Timeout: run still busy after %0d cycles", cycles);
         $display("SIMULATION FAILED");
         $fatal(1, "Cycle limit reached");
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Test table input
   task automatic load_tests();
      int          fd;
      int          n;
      string       line;
      string       name;
      logic [31:0] f_mode;
      logic [31:0] f_freq;
      logic [31:0] f_echo;
      logic [31:0] f_len;
      logic [31:0] f_a;
      logic [31:0] f_b;
      int unsigned f_rst;
      int unsigned f_cnt;
      fd = $fopen(TEST_FILE, "r");
      if (fd == 0) begin
         $display("Cannot open test file %0s", TEST_FILE);
         $display("SIMULATION FAILED");
         $fatal(1, "Test data missing");
      end
      while (!$feof(fd)) begin
         line = "";
         n = $fgets(line, fd);
         if (n > 0 && line.getc(0) != "#") begin  // Skip column notes
            n = $sscanf(line, "%s %h %h %h %h %h %h %d %d", name, f_mode, f_freq,
                        f_echo, f_len, f_a, f_b, f_rst, f_cnt);
            if (n == 9) begin
               t_name.push_back(name);
               t_mode.push_back(f_mode[7:0]);
               t_freq.push_back(f_freq[15:0]);
               t_echo.push_back(f_echo);
               t_len.push_back(f_len[3:0]);
               t_adc_a.push_back(f_a[13:0]);
               t_adc_b.push_back(f_b[13:0]);
               t_restart.push_back(f_rst != 0);
               t_count.push_back(f_cnt);
            end
         end
      end
      $fclose(fd);
   endtask

   //////////////////////////////////////////////////////////////////////
   // Reference model
   function automatic iq_sample_t expected_sample(input int k);
      iq_sample_t  exp;
      logic [15:0] q_phase;
      q_phase = m_phase + DBG_QUARTER_TURN;  // Q a quarter turn ahead
      case (t_mode[k])
         MODE_ADC: begin
            exp.i = dbg_word_t'($signed(t_adc_a[k]));
            exp.q = dbg_word_t'($signed(t_adc_b[k]));
         end
         MODE_TONE: begin
            exp.i = m_phase[15:1];
            exp.q = q_phase[15:1];
         end
         MODE_BURST: begin
            exp.i = (m_burst != 0) ? DBG_ONES : DBG_MARK_I;
            exp.q = (m_burst != 0) ? DBG_ONES : DBG_MARK_Q;
         end
         MODE_COUNT: begin
            exp.i = m_cnt_i;
            exp.q = m_cnt_q;
         end
         MODE_ZERO: exp = '0;
         MODE_ONES: exp = {DBG_ONES, DBG_ONES};
         MODE_I_OFF: exp = {15'd0, DBG_ONES};
         MODE_ECHO: begin
            exp.i = t_echo[k][14:0];
            exp.q = t_echo[k][30:16];
         end
         default: begin
            exp.i = {t_adc_a[k], 1'b0};  // A word times two
            exp.q = {t_adc_a[k], 1'b0};
         end
      endcase
      return exp;
   endfunction

   // All sources move on with every sample sent
   task automatic model_step(input int k);
      m_phase = m_phase + t_freq[k];
      m_cnt_i = m_cnt_i + 15'd1;
      m_cnt_q = m_cnt_q + 15'd1;
      if (m_burst != 0) begin
         m_burst = m_burst - 16'd1;
      end
   endtask

   //////////////////////////////////////////////////////////////////////
   // Compare tasks
   task automatic check_sample(input string name, input iq_sample_t exp,
                               input iq_sample_t act);
      if (act !== exp) begin
         $display("CHECK FAILED %0s: expected I=%h Q=%h, actual I=%h Q=%h",
                  name, exp.i, exp.q, act.i, act.q);
         $display("SIMULATION FAILED");
         $fatal(1, "Sample mismatch");
      end
   endtask

   task automatic check_valid_count(input string name, input credit_count_t exp,
                                    input credit_count_t act);
      if (act !== exp) begin
         $display("CHECK FAILED %0s: expected %0d valid cycles, actual %0d",
                  name, exp, act);
         $display("SIMULATION FAILED");
         $fatal(1, "Valid count mismatch");
      end
   endtask

   // Valid pulses over an idle window, saturating
   task automatic count_valids(input int unsigned ncycles, output credit_count_t seen);
      seen = '0;
      repeat (ncycles) begin
         @(negedge dsp_clk);
         if (dbg_valid === 1'b1 && seen != DBG_MAX_CREDITS) begin
            seen = seen + 4'd1;
         end
      end
   endtask

   //////////////////////////////////////////////////////////////////////
   // Stimulus
   task automatic write_reg(input logic [7:0] offset, input logic [31:0] value);
      @(posedge dsp_clk);
      set_bus <= '{stb: 1'b1, addr: DBG_SR_BASE + offset, data: value};
   endtask

   // Length before mode so a burst restart sees the new length
   task automatic configure(input int k);
      int unsigned n;
      write_reg(DBG_SR_FREQ, 32'(t_freq[k]));
      write_reg(DBG_SR_ECHO, t_echo[k]);
      write_reg(DBG_SR_TESTLEN, 32'(t_len[k]));
      if (t_restart[k] || t_mode[k] != cur_mode) begin
         write_reg(DBG_SR_MODE, 32'(t_mode[k]));
         cur_mode = t_mode[k];
         if (t_mode[k] == MODE_BURST) begin
            m_burst = 16'd1;
            for (n = 0; n < t_len[k]; n++) begin
               m_burst = m_burst * 16'd2;
            end
         end
      end
      @(posedge dsp_clk);
      set_bus <= '0;
      adc_a   <= t_adc_a[k];
      adc_b   <= t_adc_b[k];
      @(posedge dsp_clk);
   endtask

   task automatic run_test(input int k);
      credit_count_t stray;
      configure(k);
      granted   = 0;
      collected = 0;
      fork
         begin
            // Sink side, never more than the credit limit outstanding
            while (granted < t_count[k]) begin
               @(posedge dsp_clk);
               if ((granted - collected < 32'(DBG_MAX_CREDITS)) &&
                   (($urandom % 3) != 0)) begin
                  credit  <= 1'b1;
                  granted = granted + 1;
               end else begin
                  credit <= 1'b0;
               end
            end
            @(posedge dsp_clk);
            credit <= 1'b0;
         end
         begin
            while (collected < t_count[k]) begin
               @(negedge dsp_clk);
               if (dbg_valid === 1'b1) begin
                  check_sample(t_name[k], expected_sample(k), dbg_sample);
                  model_step(k);
                  collected = collected + 1;
               end
            end
         end
      join
      count_valids(4, stray);  // No sample beyond the credits
      check_valid_count(t_name[k], '0, stray);
   endtask

   initial begin
      int unsigned   total;
      credit_count_t stray;
      void'($urandom(21));
      dsp_clk  = 1'b0;
      dsp_rst  = 1'b1;
      set_bus  = '0;
      adc_a    = '0;
      adc_b    = '0;
      credit   = 1'b0;
      m_phase  = '0;
      m_cnt_i  = '0;
      m_cnt_q  = DBG_COUNT_Q_INIT;
      m_burst  = '0;
      cur_mode = MODE_ADC;
      load_tests();
      if (t_name.size() == 0) begin
         $display("Test file %0s holds no tests", TEST_FILE);
         $display("SIMULATION FAILED");
         $fatal(1, "Empty test table");
      end
      total = 0;
      foreach (t_count[k]) begin
         total = total + t_count[k];
      end
      cycle_limit = total * 8 + 200;

      repeat (10) @(posedge dsp_clk);
      dsp_rst <= 1'b0;
      count_valids(8, stray);  // Quiet until the first credit
      check_valid_count("reset_idle", '0, stray);

      foreach (t_name[k]) begin
         run_test(k);
      end
      $display("SIMULATION PASSED");
      $finish;
   end

endmodule

//--- verif/debug_tap_tests.txt
# name         mode freq echo     len adc_a adc_b rst count
# mode to adc_b in hex, rst (burst restart) and count in decimal
adc_pos        00   0000 00000000 0   0123  0456  0   6
adc_neg        00   0000 00000000 0   2abc  3fff  0   6
zero           04   0000 00000000 0   0000  0000  0   4
ones           05   0000 00000000 0   0000  0000  0   4
i_off          06   0000 00000000 0   0000  0000  0   4
echo           07   0000 7abc5def 0   0000  0000  0   4
echo_max       07   0000 ffffffff 0   0000  0000  0   4
default_9      09   0000 00000000 0   1234  0abc  0   5
default_neg    09   0000 00000000 0   3fff  0001  0   5
default_ff     ff   0000 00000000 0   2001  1555  0   3
tone_a         01   0123 00000000 0   0000  0000  0   20
tone_b         01   0f00 00000000 0   0000  0000  0   20
count          03   0000 00000000 0   0000  0000  0   24
burst          02   0000 00000000 3   0000  0000  1   12
burst_tail     02   0000 00000000 3   0000  0000  0   4
burst_again    02   0000 00000000 3   0000  0000  1   10
burst_long     02   0000 00000000 5   0000  0000  1   40
adc_mix        00   0000 00000000 0   1fff  2000  0   8
tone_fast      01   7777 00000000 0   0000  0000  0   48
count_more     03   0000 00000000 0   0000  0000  0   48

//--- tb.f
rtl/dbg_cfg_pkg.sv
rtl/dbg_sample_pkg.sv
rtl/debug_settings.sv
rtl/phase_ramp_gen.sv
rtl/test_pattern_gen.sv
rtl/capture_select.sv
rtl/dsp_debug_tap.sv
verif/dsp_debug_tap_sva.sv
verif/tb_dsp_debug_tap.sv

//--- run_sim.sh
#!/bin/sh
# Compile and run the debug tap testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
   --top-module tb_dsp_debug_tap -f tb.f

output=$(./obj_dir/Vtb_dsp_debug_tap 2>&1) || true
printf '%s\n' "$output"

if printf '%s\n' "$output" | grep -q "SIMULATION PASSED"; then
   exit 0
fi
exit 1
